/* Bender.yml */
package:
  name: imem_frontend

sources:
  - hw/imem_pkg.sv
  - hw/packet_sram.sv
  - hw/packet_ctrl.sv
  - hw/command_fifo.sv
  - hw/task_decoder.sv
  - hw/reservation_station.sv
  - hw/packet_sram_integration.sv
  - target: test
    files:
      - verification/imem_assert.sv
      - verification/imem_tb.sv

/* compile.f */
hw/imem_pkg.sv
hw/packet_sram.sv
hw/packet_ctrl.sv
hw/command_fifo.sv
hw/task_decoder.sv
hw/reservation_station.sv
hw/packet_sram_integration.sv
verification/imem_assert.sv
verification/imem_tb.sv

/* hw/command_fifo.sv */
module command_fifo #(
    parameter type entry_t = imem_pkg::com_packet_t,
    parameter int  depth   = imem_pkg::fifo_depth
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         push,
    input  entry_t                       push_data,
    input  logic                         pop,
    output entry_t                       head,
    output logic                         empty,
    output logic                         full,
    output logic [$clog2(depth+1)-1:0]   count
);

    localparam int aw = (depth > 1) ? $clog2(depth) : 1;
    localparam int cw = $clog2(depth + 1);

    entry_t          mem [depth];
    logic [aw-1:0]   wr_ptr_q;
    logic [aw-1:0]   rd_ptr_q;
    logic [cw-1:0]   count_q;
    logic            do_push;
    logic            do_pop;

    assign empty = (count_q == '0);
    assign full  = (count_q == cw'(depth));
    assign count = count_q;
    assign head  = mem[rd_ptr_q];   // show-ahead

    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop);

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == aw'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == aw'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

/* hw/imem_pkg.sv */
package imem_pkg;

    localparam int packet_size = 32;
    localparam int pkt_type_size = 2;
    localparam int payload_size = packet_size - pkt_type_size;

    localparam int num_edge_pe = 4;
    localparam int lane_w = $clog2(num_edge_pe);

    localparam int sram_depth = 64;
    localparam int sram_aw = $clog2(sram_depth);

    localparam int fifo_depth = 4;
    localparam int fifo_cw = $clog2(fifo_depth + 1);
    localparam int rs_depth = 4;

    localparam int max_replay_iter = 8;
    localparam int max_fv_num = 16;
    localparam int max_num_weight_layer = 4;
    localparam int replay_w = $clog2(max_replay_iter);
    localparam int fv_w = $clog2(max_fv_num) + 1;     // 0..16 inclusive
    localparam int wb_w = $clog2(max_num_weight_layer);

    typedef enum logic [pkt_type_size-1:0] {
        pkt_task   = 2'd0,
        pkt_config = 2'd1,
        pkt_marker = 2'd2,
        pkt_end    = 2'd3
    } pkt_type_e;

    // type sits in the top two bits of a lane packet
    typedef struct packed {
        pkt_type_e                kind;
        logic [payload_size-1:0]  payload;
    } com_packet_t;

    typedef struct packed {
        logic [lane_w-1:0]        lane;    // payload bits 29..28
        logic [payload_size-1:0]  payload;
    } rs_task_t;

    typedef struct packed {
        logic [payload_size-wb_w-fv_w-replay_w-1:0] unused;
        logic [wb_w-1:0]          weights_boundary;  // bits 9..8
        logic [fv_w-1:0]          num_fv;            // bits 7..3
        logic [replay_w-1:0]      replay_iter;       // bits 2..0
    } cfg_payload_t;

endpackage

/* hw/packet_ctrl.sv */
module packet_ctrl (
    input  logic                                                      clk,
    input  logic                                                      reset,
    input  logic [imem_pkg::num_edge_pe-1:0][imem_pkg::packet_size-1:0] in_packet,
    input  logic [imem_pkg::num_edge_pe-1:0]                          in_valid,
    input  logic [imem_pkg::fifo_cw-1:0]                              fifo_count,
    input  imem_pkg::com_packet_t                                     sram_rd_data,
    output logic                                                      in_ready,
    output logic                                                      sram_wr_en,
    output logic [imem_pkg::sram_aw-1:0]                              sram_wr_addr,
    output imem_pkg::com_packet_t                                     sram_wr_data,
    output logic                                                      sram_rd_en,
    output logic [imem_pkg::sram_aw-1:0]                              sram_rd_addr,
    output logic                                                      fifo_push,
    output imem_pkg::com_packet_t                                     fifo_data
);

    import imem_pkg::*;

    com_packet_t          stage_q [num_edge_pe];
    logic [num_edge_pe-1:0] pend_q;
    logic [lane_w-1:0]    drain_lane;
    logic [sram_aw-1:0]   wr_ptr_q;
    logic [sram_aw-1:0]   rd_ptr_q;
    logic                 rd_inflight_q;
    logic [fifo_cw:0]     fifo_claim;
    logic                 capture;

    assign in_ready = (pend_q == '0);
    assign capture  = in_ready && (|in_valid);

    // lowest pending lane goes first
    always_comb begin
        drain_lane = '0;
        for (int i = num_edge_pe - 1; i >= 0; i--) begin
            if (pend_q[i]) begin
                drain_lane = lane_w'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            for (int i = 0; i < num_edge_pe; i++) begin
                stage_q[i] <= com_packet_t'(in_packet[i]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pend_q   <= '0;
            wr_ptr_q <= '0;
        end else if (capture) begin
            pend_q <= in_valid;
        end else if (sram_wr_en) begin
            pend_q[drain_lane] <= 1'b0;
            wr_ptr_q           <= wr_ptr_q + 1'b1;  // wraps at sram_depth
        end
    end

    assign sram_wr_en   = |pend_q;
    assign sram_wr_addr = wr_ptr_q;
    assign sram_wr_data = stage_q[drain_lane];

    // entries already in the FIFO plus the one on its way
    assign fifo_claim   = fifo_count + rd_inflight_q;
    assign sram_rd_en   = (wr_ptr_q != rd_ptr_q) && (fifo_claim < fifo_depth);
    assign sram_rd_addr = rd_ptr_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr_q      <= '0;
            rd_inflight_q <= 1'b0;
        end else begin
            rd_inflight_q <= sram_rd_en;
            if (sram_rd_en) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    assign fifo_push = rd_inflight_q;
    assign fifo_data = sram_rd_data;

endmodule

/* hw/packet_sram.sv */
module packet_sram (
    input  logic                         clk,
    input  logic                         wr_en,
    input  logic [imem_pkg::sram_aw-1:0] wr_addr,
    input  imem_pkg::com_packet_t        wr_data,
    input  logic                         rd_en,
    input  logic [imem_pkg::sram_aw-1:0] rd_addr,
    output imem_pkg::com_packet_t        rd_data
);

    import imem_pkg::*;

    com_packet_t mem [sram_depth];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read port, data valid one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* hw/packet_sram_integration.sv */
module packet_sram_integration (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [imem_pkg::packet_size-1:0]  in_packet_0,
    input  logic [imem_pkg::packet_size-1:0]  in_packet_1,
    input  logic [imem_pkg::packet_size-1:0]  in_packet_2,
    input  logic [imem_pkg::packet_size-1:0]  in_packet_3,
    input  logic [3:0]                      in_valid,
    input  logic [3:0]                      pe_idle,
    input  logic [3:0]                      bank_busy,
    input  logic                            outbuff_available,
    output logic                            in_ready,
    output logic [imem_pkg::payload_size-1:0] out_packet_0,
    output logic [imem_pkg::payload_size-1:0] out_packet_1,
    output logic [imem_pkg::payload_size-1:0] out_packet_2,
    output logic [imem_pkg::payload_size-1:0] out_packet_3,
    output logic [3:0]                      out_valid,
    output logic [imem_pkg::replay_w-1:0]   replay_iter,
    output logic [imem_pkg::fv_w-1:0]       num_fv,
    output logic [imem_pkg::wb_w-1:0]       weights_boundary,
    output logic                            stream_begin,
    output logic                            task_complete
);

    import imem_pkg::*;

    logic [num_edge_pe-1:0][packet_size-1:0]  lane_packet;
    logic [num_edge_pe-1:0][payload_size-1:0] rs_out_packet;
    logic               sram_wr_en;
    logic [sram_aw-1:0] sram_wr_addr;
    com_packet_t        sram_wr_data;
    logic               sram_rd_en;
    logic [sram_aw-1:0] sram_rd_addr;
    com_packet_t        sram_rd_data;
    logic [fifo_cw-1:0] fifo_count;
    logic               fifo_push;
    com_packet_t        fifo_data;
    com_packet_t        cmd_head;
    logic               cmd_empty;
    logic               cmd_pop;
    logic               rs_push;
    rs_task_t           rs_task;
    logic               rs_full;
    logic               rs_empty;

    assign lane_packet = {in_packet_3, in_packet_2, in_packet_1, in_packet_0};

    assign out_packet_0 = rs_out_packet[0];
    assign out_packet_1 = rs_out_packet[1];
    assign out_packet_2 = rs_out_packet[2];
    assign out_packet_3 = rs_out_packet[3];

    packet_sram packet_sram_0 (
        .clk     (clk),
        .wr_en   (sram_wr_en),
        .wr_addr (sram_wr_addr),
        .wr_data (sram_wr_data),
        .rd_en   (sram_rd_en),
        .rd_addr (sram_rd_addr),
        .rd_data (sram_rd_data)
    );

    packet_ctrl packet_ctrl_0 (
        .clk          (clk),
        .reset        (reset),
        .in_packet    (lane_packet),
        .in_valid     (in_valid),
        .fifo_count   (fifo_count),
        .sram_rd_data (sram_rd_data),
        .in_ready     (in_ready),
        .sram_wr_en   (sram_wr_en),
        .sram_wr_addr (sram_wr_addr),
        .sram_wr_data (sram_wr_data),
        .sram_rd_en   (sram_rd_en),
        .sram_rd_addr (sram_rd_addr),
        .fifo_push    (fifo_push),
        .fifo_data    (fifo_data)
    );

    command_fifo #(
        .entry_t (com_packet_t),
        .depth   (fifo_depth)
    ) command_fifo_0 (
        .clk       (clk),
        .reset     (reset),
        .push      (fifo_push),
        .push_data (fifo_data),
        .pop       (cmd_pop),
        .head      (cmd_head),
        .empty     (cmd_empty),
        .full      (),            // packet_ctrl bounds reads by count
        .count     (fifo_count)
    );

    task_decoder task_decoder_0 (
        .clk               (clk),
        .reset             (reset),
        .head              (cmd_head),
        .empty             (cmd_empty),
        .rs_full           (rs_full),
        .rs_empty          (rs_empty),
        .outbuff_available (outbuff_available),
        .pop               (cmd_pop),
        .rs_push           (rs_push),
        .rs_task           (rs_task),
        .replay_iter       (replay_iter),
        .num_fv            (num_fv),
        .weights_boundary  (weights_boundary),
        .stream_begin      (stream_begin),
        .task_complete     (task_complete)
    );

    reservation_station rs_0 (
        .clk        (clk),
        .reset      (reset),
        .push       (rs_push),
        .task_in    (rs_task),
        .pe_idle    (pe_idle),
        .bank_busy  (bank_busy),
        .out_packet (rs_out_packet),
        .out_valid  (out_valid),
        .rs_empty   (rs_empty),
        .rs_full    (rs_full)
    );

endmodule

/* hw/reservation_station.sv */
module reservation_station (
    input  logic                                                       clk,
    input  logic                                                       reset,
    input  logic                                                       push,
    input  imem_pkg::rs_task_t                                         task_in,
    input  logic [imem_pkg::num_edge_pe-1:0]                           pe_idle,
    input  logic [imem_pkg::num_edge_pe-1:0]                           bank_busy,
    output logic [imem_pkg::num_edge_pe-1:0][imem_pkg::payload_size-1:0] out_packet,
    output logic [imem_pkg::num_edge_pe-1:0]                           out_valid,
    output logic                                                       rs_empty,
    output logic                                                       rs_full
);

    import imem_pkg::*;

    rs_task_t head_task;
    logic     lane_ready;
    logic     dispatch;

    command_fifo #(
        .entry_t (rs_task_t),
        .depth   (rs_depth)
    ) task_queue (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .push_data (task_in),
        .pop       (dispatch),
        .head      (head_task),
        .empty     (rs_empty),
        .full      (rs_full),
        .count     ()
    );

    // only the head is looked at, later tasks wait behind it
    assign lane_ready = pe_idle[head_task.lane] && !bank_busy[head_task.lane];
    assign dispatch   = !rs_empty && lane_ready;

    always_ff @(posedge clk) begin
        if (dispatch) begin
            out_packet[head_task.lane] <= head_task.payload;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= '0;
        end else if (dispatch) begin
            out_valid <= num_edge_pe'(1) << head_task.lane;   // one lane per cycle
        end else begin
            out_valid <= '0;
        end
    end

endmodule

/* hw/task_decoder.sv */
module task_decoder (
    input  logic                          clk,
    input  logic                          reset,
    input  imem_pkg::com_packet_t         head,
    input  logic                          empty,
    input  logic                          rs_full,
    input  logic                          rs_empty,
    input  logic                          outbuff_available,
    output logic                          pop,
    output logic                          rs_push,
    output imem_pkg::rs_task_t            rs_task,
    output logic [imem_pkg::replay_w-1:0] replay_iter,
    output logic [imem_pkg::fv_w-1:0]     num_fv,
    output logic [imem_pkg::wb_w-1:0]     weights_boundary,
    output logic                          stream_begin,
    output logic                          task_complete
);

    import imem_pkg::*;

    cfg_payload_t cfg;
    logic         head_go;

    assign cfg = cfg_payload_t'(head.payload);

    // stall rules per head type
    always_comb begin
        case (head.kind)
            pkt_task:   head_go = !rs_full;
            pkt_config: head_go = 1'b1;
            pkt_marker: head_go = outbuff_available;
            pkt_end:    head_go = rs_empty;     // all earlier tasks gone
            default:    head_go = 1'b0;
        endcase
    end

    assign pop     = !empty && head_go;
    assign rs_push = pop && (head.kind == pkt_task);

    assign rs_task.lane    = head.payload[payload_size-1 -: lane_w];
    assign rs_task.payload = head.payload;

    always_ff @(posedge clk) begin
        if (reset) begin
            replay_iter      <= '0;
            num_fv           <= '0;
            weights_boundary <= '0;
        end else if (pop && (head.kind == pkt_config)) begin
            replay_iter      <= cfg.replay_iter;
            num_fv           <= cfg.num_fv;
            weights_boundary <= cfg.weights_boundary;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stream_begin  <= 1'b0;
            task_complete <= 1'b0;
        end else begin
            stream_begin  <= pop && (head.kind == pkt_marker);
            task_complete <= pop && (head.kind == pkt_end);
        end
    end

endmodule

/* verification/imem_assert.sv */
module imem_assert (
    input logic       clk,
    input logic       reset,
    input logic [3:0] in_valid,
    input logic       in_ready,
    input logic [3:0] pe_idle,
    input logic [3:0] bank_busy,
    input logic [3:0] out_valid,
    input logic       stream_begin,
    input logic       task_complete
);

    int fail_count;

    assert property (@(posedge clk) disable iff (reset) $onehot0(out_valid))
        else begin
            fail_count++;
            $error("out_valid has more than one lane set");
        end

    // dispatch decision is one cycle before the valid pulse
    assert property (@(posedge clk) disable iff (reset)
        (out_valid & ~$past(pe_idle & ~bank_busy)) == 4'b0000)
        else begin
            fail_count++;
            $error("dispatch to a lane that was not idle or had its bank busy");
        end

    assert property (@(posedge clk) disable iff (reset) (in_ready && |in_valid) |=> !in_ready)
        else begin
            fail_count++;
            $error("in_ready still high after a capture");
        end

    assert property (@(posedge clk) disable iff (reset) stream_begin |=> !stream_begin)
        else begin
            fail_count++;
            $error("stream_begin held for two cycles");
        end

    assert property (@(posedge clk) disable iff (reset) task_complete |=> !task_complete)
        else begin
            fail_count++;
            $error("task_complete held for two cycles");
        end

endmodule

/* verification/imem_tb.sv */
module imem_tb;

    import imem_pkg::*;

    localparam int timeout_cycles = 5000;

    logic        clk;
    logic        reset;
    logic [31:0] in_packet_0;
    logic [31:0] in_packet_1;
    logic [31:0] in_packet_2;
    logic [31:0] in_packet_3;
    logic [3:0]  in_valid;
    logic [3:0]  pe_idle;
    logic [3:0]  bank_busy;
    logic        outbuff_available;
    logic        in_ready;
    logic [29:0] out_packet_0;
    logic [29:0] out_packet_1;
    logic [29:0] out_packet_2;
    logic [29:0] out_packet_3;
    logic [3:0]  out_valid;
    logic [2:0]  replay_iter;
    logic [4:0]  num_fv;
    logic [1:0]  weights_boundary;
    logic        stream_begin;
    logic        task_complete;

    logic [29:0] out_pkt [4];
    logic [29:0] exp_q [$];     // expected dispatch payloads, in order
    string       test_name;
    int          errors;
    int          disp_count;
    int          sb_count;
    int          tc_count;
    int          cycle_count;

    assign out_pkt[0] = out_packet_0;
    assign out_pkt[1] = out_packet_1;
    assign out_pkt[2] = out_packet_2;
    assign out_pkt[3] = out_packet_3;

    packet_sram_integration DUT (.*);

    bind packet_sram_integration imem_assert imem_assert_0 (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .pe_idle       (pe_idle),
        .bank_busy     (bank_busy),
        .out_valid     (out_valid),
        .stream_begin  (stream_begin),
        .task_complete (task_complete)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic check_equal(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s: %s expected %0h, actual %0h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic compare_dispatch(input int lane, input logic [29:0] payload);
        logic [29:0] exp;
        disp_count++;
        if (exp_q.size() == 0) begin
            $display("dispatch on lane %0d in test %s with no task outstanding", lane, test_name);
            errors++;
        end else begin
            exp = exp_q.pop_front();
            check_equal("dispatch lane", 32'(exp[29:28]), 32'(lane));
            check_equal("dispatch payload", 32'(exp), 32'(payload));
        end
    endtask

    // sampled mid-cycle, away from the rising edge
    always @(negedge clk) begin
        if (!reset) begin
            if (stream_begin) sb_count++;
            if (task_complete) begin
                tc_count++;
                check_equal("tasks pending at task_complete", 0, exp_q.size());
            end
            for (int i = 0; i < 4; i++) begin
                if (out_valid[i]) compare_dispatch(i, out_pkt[i]);
            end
        end
    end

    function automatic logic [31:0] task_pkt(input logic [1:0] lane);
        logic [31:0] r;
        r = $urandom();
        return {2'b00, lane, r[27:0]};  // payload 29..28 picks the PE
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic send_capture(input logic [3:0] valid, input logic [3:0][31:0] pkts);
        while (!in_ready) idle_cycles(1);
        in_packet_0 = pkts[0];
        in_packet_1 = pkts[1];
        in_packet_2 = pkts[2];
        in_packet_3 = pkts[3];
        in_valid    = valid;
        for (int i = 0; i < 4; i++) begin
            if (valid[i] && pkts[i][31:30] == 2'b00) exp_q.push_back(pkts[i][29:0]);
        end
        idle_cycles(1);
        in_valid = '0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) idle_cycles(1);
    endtask

    task automatic test_reset_state();
        test_name = "reset_state";
        check_equal("out_valid", 0, out_valid);
        check_equal("stream_begin", 0, stream_begin);
        check_equal("task_complete", 0, task_complete);
        check_equal("in_ready", 1, in_ready);
        check_equal("replay_iter", 0, replay_iter);
        check_equal("num_fv", 0, num_fv);
        check_equal("weights_boundary", 0, weights_boundary);
    endtask

    task automatic test_single_task();
        test_name = "single_task";
        send_capture(4'b0001, {96'h0, task_pkt(2'd2)});
        wait_drain();
    endtask

    task automatic test_ordering();
        test_name = "ordering";
        send_capture(4'b1111, {task_pkt(2'd0), task_pkt(2'd1), task_pkt(2'd3), task_pkt(2'd2)});
        send_capture(4'b1010, {task_pkt(2'd1), task_pkt(2'd3), task_pkt(2'd0), task_pkt(2'd1)});
        send_capture(4'b0111, {task_pkt(2'd3), task_pkt(2'd2), task_pkt(2'd2), task_pkt(2'd0)});
        wait_drain();
    endtask

    task automatic test_config();
        logic [31:0] r;
        test_name = "config";
        r = $urandom();
        send_capture(4'b0111, {task_pkt(2'd1), task_pkt(2'd3), {2'b01, r[29:0]}, task_pkt(2'd0)});
        wait_drain();
        check_equal("replay_iter", 32'(r[2:0]), replay_iter);
        check_equal("num_fv", 32'(r[7:3]), num_fv);
        check_equal("weights_boundary", 32'(r[9:8]), weights_boundary);
    endtask

    task automatic test_back_pressure();
        int base;
        logic [31:0] r;
        test_name = "back_pressure";
        bank_busy = 4'b0010;
        base = disp_count;
        send_capture(4'b0011, {64'h0, task_pkt(2'd0), task_pkt(2'd1)});
        idle_cycles(20);
        check_equal("dispatches while lane 1 busy", base, disp_count);
        bank_busy = 4'b0000;
        wait_drain();
        pe_idle = 4'b0111;
        base = disp_count;
        send_capture(4'b0011, {64'h0, task_pkt(2'd2), task_pkt(2'd3)});
        idle_cycles(20);
        check_equal("dispatches while lane 3 not idle", base, disp_count);
        pe_idle = 4'b1111;
        wait_drain();
        outbuff_available = 1'b0;
        base = sb_count;
        r = $urandom();
        send_capture(4'b0001, {96'h0, {2'b10, r[29:0]}});
        idle_cycles(20);
        check_equal("stream_begin pulses while blocked", base, sb_count);
        outbuff_available = 1'b1;
        while (sb_count == base) idle_cycles(1);
        idle_cycles(10);
        check_equal("stream_begin pulses", base + 1, sb_count);
    endtask

    task automatic test_completion();
        int base;
        test_name = "completion";
        bank_busy = 4'b0100;
        base = tc_count;
        send_capture(4'b0111, {32'h0, {2'b11, 30'h0}, task_pkt(2'd0), task_pkt(2'd2)});
        idle_cycles(20);
        check_equal("task_complete while tasks pending", base, tc_count);
        bank_busy = 4'b0000;
        while (tc_count == base) idle_cycles(1);
        idle_cycles(10);
        check_equal("task_complete pulses", base + 1, tc_count);
    endtask

    initial begin
        void'($urandom(32'hca84632a));
        reset             = 1'b1;
        in_packet_0       = '0;
        in_packet_1       = '0;
        in_packet_2       = '0;
        in_packet_3       = '0;
        in_valid          = '0;
        pe_idle           = 4'b1111;
        bank_busy         = 4'b0000;
        outbuff_available = 1'b1;
        test_name         = "reset";
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        test_reset_state();
        test_single_task();
        test_ordering();
        test_config();
        test_back_pressure();
        test_completion();
        idle_cycles(5);
        errors += DUT.imem_assert_0.fail_count;
        $display("errors: %0d, dispatches checked: %0d", errors, disp_count);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
